// ==== common/dif_defs.svh ====
`ifndef DIF_DEFS_SVH
`define DIF_DEFS_SVH

// Host word and setting widths
`define CMD_W          16
`define DAC_CODE_W     12
`define DAC_WORD_W     16          // Control nibble plus code
`define HV_VALUE_W     16          // Four hex digits

// Slow-control register clock
`define SC_FRAME_W     32
`define SC_HALF_DIV    4           // Sys cycles per sr_ck half period

// TLV5618 serial port
`define DAC_HALF_DIV   2           // Sys cycles per sclk half period
`define DAC_CTRL_CH_A  4'b1100     // R1 SPD PWR R0, write channel A

// HV module UART
`define HV_BAUD_DIV    16          // Sys cycles per UART bit
`define HV_PREFIX      24'h484256  // "HBV"
`define HV_BYTES       7

`endif

// ==== common/dif_pkg.sv ====
package dif_pkg;

	// Host opcode in control word bits 15..12
	typedef enum logic [3:0]
	{
		OP_SET_THR     = 4'h1,   // Trigger threshold, 10 bits
		OP_SET_CTRL    = 4'h2,   // Feedback cap, val_evt, only_ex_trig
		OP_SET_MASK_LO = 4'h3,
		OP_SET_MASK_HI = 4'h4,
		OP_START_SC    = 4'h5,   // Load ASIC config frame
		OP_SET_DAC     = 4'h6,   // Code and write in one go
		OP_SET_HV_HI   = 4'h7,   // HV digits 1 and 2
		OP_SET_HV_LO   = 4'h8,   // HV digits 3 and 4
		OP_START_HV    = 4'h9
	} cmd_op_e;

	// Slow-control frame, shifted out MSB first
	typedef struct packed
	{
		logic [9:0]  threshold;
		logic [3:0]  fb_cap;
		logic        val_evt;
		logic        only_ex_trig;
		logic [15:0] mask;
	} sc_frame_t;

	//////////////////////////////////////////////////////////////
	// Engine FSM states
	//////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {SC_IDLE, SC_SETUP, SC_HIGH, SC_LOW} sc_state_e;

	typedef enum logic [1:0] {DAC_IDLE, DAC_SETUP, DAC_HIGH, DAC_LOW} dac_state_e;

	typedef enum logic [1:0] {HV_IDLE, HV_START, HV_DATA, HV_STOP} hv_state_e;

endpackage

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module cmd_decoder
(
	input  logic                   rst_n_i,
	input  logic                   Clk_Out_2_All,
	input  logic                   cmd_valid_i,   // One strobe per host word
	input  logic [`CMD_W-1:0]      cmd_word_i,
	output dif_pkg::sc_frame_t     sc_frame_o,    // Held ASIC settings
	output logic                   sc_start_o,
	output logic [`DAC_CODE_W-1:0] dac_code_o,
	output logic                   dac_start_o,
	output logic [`HV_VALUE_W-1:0] hv_value_o,    // Digit 1 in top nibble
	output logic                   hv_start_o
);
	import dif_pkg::*;

	cmd_op_e op;

	assign op = cmd_op_e'(cmd_word_i[`CMD_W-1 -: 4]);   // Top nibble

	//////////////////////////////////////////////////////////////
	// Settings and start pulses, one cycle after the valid word
	//////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sc_frame_o  <= '0;
			sc_start_o  <= 1'b0;
			dac_code_o  <= '0;
			dac_start_o <= 1'b0;
			hv_value_o  <= '0;
			hv_start_o  <= 1'b0;
		end
		else
		begin
			sc_start_o  <= 1'b0;   // Pulses last one cycle
			dac_start_o <= 1'b0;
			hv_start_o  <= 1'b0;
			if (cmd_valid_i)
			begin
				case (op)
					OP_SET_THR:     sc_frame_o.threshold <= cmd_word_i[9:0];
					OP_SET_CTRL:
					begin
						sc_frame_o.fb_cap       <= cmd_word_i[3:0];
						sc_frame_o.val_evt      <= cmd_word_i[4];   // Discriminator enable
						sc_frame_o.only_ex_trig <= cmd_word_i[5];
					end
					OP_SET_MASK_LO: sc_frame_o.mask[7:0]  <= cmd_word_i[7:0];
					OP_SET_MASK_HI: sc_frame_o.mask[15:8] <= cmd_word_i[7:0];
					OP_START_SC:    sc_start_o <= 1'b1;
					OP_SET_DAC:
					begin
						dac_code_o  <= cmd_word_i[`DAC_CODE_W-1:0];
						dac_start_o <= 1'b1;   // Code goes out right away
					end
					OP_SET_HV_HI:   hv_value_o[15:8] <= cmd_word_i[7:0];
					OP_SET_HV_LO:   hv_value_o[7:0]  <= cmd_word_i[7:0];
					OP_START_HV:    hv_start_o <= 1'b1;
					default:        ;   // Unknown opcode, nothing changes
				endcase
			end
		end
	end

	// Host side must never present X on a valid word
	a_word_known: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		cmd_valid_i |-> !$isunknown(cmd_word_i));

endmodule

// ==== slow_control/sc_loader.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module sc_loader
(
	input  logic               rst_n_i,
	input  logic               Clk_Out_2_All,
	input  dif_pkg::sc_frame_t sc_frame_i,
	input  logic               sc_start_i,    // Dropped while busy
	output logic               sr_ck_o,       // ASIC samples on rising edge
	output logic               sr_in_o,
	output logic               sc_busy_o
);
	import dif_pkg::*;

	sc_state_e                         state;
	logic [$clog2(`SC_HALF_DIV)-1:0]   half_cnt;    // Cycles within a half period
	logic [$clog2(`SC_FRAME_W)-1:0]    bit_cnt;
	logic [`SC_FRAME_W-1:0]            shift_q;     // MSB is on the pin
	logic                              half_last;

	assign half_last = (half_cnt == (`SC_HALF_DIV - 1));
	assign sr_in_o   = shift_q[`SC_FRAME_W-1];
	assign sc_busy_o = (state != SC_IDLE);

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state    <= SC_IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
			shift_q  <= '0;
			sr_ck_o  <= 1'b0;
		end
		else
		begin
			if (state != SC_IDLE)
				half_cnt <= half_last ? '0 : half_cnt + 1'b1;
			case (state)
				SC_IDLE:
				begin
					bit_cnt <= '0;
					if (sc_start_i)
					begin
						shift_q <= sc_frame_i;   // Frame frozen for the whole load
						state   <= SC_SETUP;
					end
				end
				SC_SETUP:   // First bit settles with sr_ck low
					if (half_last)
					begin
						state   <= SC_HIGH;
						sr_ck_o <= 1'b1;
					end
				SC_HIGH:
					if (half_last)
					begin
						state   <= SC_LOW;
						sr_ck_o <= 1'b0;
					end
				SC_LOW:
				begin
					if (half_cnt == '0)
						shift_q <= {shift_q[`SC_FRAME_W-2:0], 1'b0};   // Next bit, clock low
					if (half_last)
					begin
						if (bit_cnt == (`SC_FRAME_W - 1))
							state <= SC_IDLE;   // Done after the last falling edge
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							state   <= SC_HIGH;
							sr_ck_o <= 1'b1;
						end
					end
				end
				default: state <= SC_IDLE;
			endcase
		end
	end

	// No register clock toggles outside a load
	a_ck_idle: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		(state == SC_IDLE) |-> !sr_ck_o);

endmodule

// ==== logic/dac_spi_writer.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module dac_spi_writer
(
	input  logic                   rst_n_i,
	input  logic                   Clk_Out_2_All,
	input  logic [`DAC_CODE_W-1:0] dac_code_i,
	input  logic                   dac_start_i,
	output logic                   dac_sclk_o,   // DAC samples on falling edge
	output logic                   dac_din_o,
	output logic                   dac_cs_n_o,
	output logic                   dac_busy_o
);
	import dif_pkg::*;

	dac_state_e                        state;
	logic [$clog2(`DAC_HALF_DIV)-1:0]  half_cnt;
	logic [$clog2(`DAC_WORD_W)-1:0]    bit_cnt;
	logic [`DAC_WORD_W-1:0]            word_q;     // Ctrl nibble then code
	logic                              half_last;

	assign half_last  = (half_cnt == (`DAC_HALF_DIV - 1));
	assign dac_busy_o = (state != DAC_IDLE);

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state      <= DAC_IDLE;
			half_cnt   <= '0;
			bit_cnt    <= '0;
			word_q     <= '0;
			dac_sclk_o <= 1'b0;
			dac_din_o  <= 1'b0;
			dac_cs_n_o <= 1'b1;
		end
		else
		begin
			if (state != DAC_IDLE)
				half_cnt <= half_last ? '0 : half_cnt + 1'b1;
			case (state)
				DAC_IDLE:
				begin
					bit_cnt <= '0;
					if (dac_start_i)
					begin
						word_q     <= {`DAC_CTRL_CH_A, dac_code_i};
						dac_cs_n_o <= 1'b0;   // Frame opens
						state      <= DAC_SETUP;
					end
				end
				DAC_SETUP, DAC_LOW:
					if (half_last)
					begin
						if (state == DAC_LOW && bit_cnt == (`DAC_WORD_W - 1))
						begin
							dac_cs_n_o <= 1'b1;   // 16th bit taken, latch DAC
							state      <= DAC_IDLE;
						end
						else
						begin
							if (state == DAC_LOW)
								bit_cnt <= bit_cnt + 1'b1;
							dac_sclk_o <= 1'b1;                  // Rising edge
							dac_din_o  <= word_q[`DAC_WORD_W-1]; // Data moves with it
							word_q     <= {word_q[`DAC_WORD_W-2:0], 1'b0};
							state      <= DAC_HIGH;
						end
					end
				DAC_HIGH:
					if (half_last)
					begin
						dac_sclk_o <= 1'b0;   // DAC samples here
						state      <= DAC_LOW;
					end
				default: state <= DAC_IDLE;
			endcase
		end
	end

	// Chip select only active inside a transfer
	a_cs_idle: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		!dac_busy_o |-> dac_cs_n_o);

endmodule

// ==== hv/hv_cmd_sender.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module hv_cmd_sender
(
	input  logic                   rst_n_i,
	input  logic                   Clk_Out_2_All,
	input  logic [`HV_VALUE_W-1:0] hv_value_i,   // Four hex digits
	input  logic                   hv_start_i,
	output logic                   hv_tx_o,      // UART line, idles high
	output logic                   hv_busy_o
);
	import dif_pkg::*;

	localparam logic [23:0] PREFIX_BYTES = `HV_PREFIX;

	hv_state_e                         state;
	logic [$clog2(`HV_BAUD_DIV)-1:0]   baud_cnt;
	logic [2:0]                        bit_cnt;     // Data bit, LSB first
	logic [$clog2(`HV_BYTES)-1:0]      byte_idx;
	logic [`HV_VALUE_W-1:0]            hv_value_q;
	logic [7:0]                        tx_byte;
	logic                              baud_last;
	logic                              hv_accept;

	// Uppercase ASCII of one hex digit
	function automatic logic [7:0] hex_to_ascii(input logic [3:0] digit);
		if (digit < 4'd10)
			return 8'h30 + {4'h0, digit};
		else
			return 8'h37 + {4'h0, digit};   // 10 maps to 'A'
	endfunction

	assign baud_last = (baud_cnt == (`HV_BAUD_DIV - 1));
	assign hv_accept = (state == HV_IDLE) && hv_start_i;
	assign hv_busy_o = (state != HV_IDLE);

	always_comb
	begin
		case (byte_idx)
			3'd0:    tx_byte = PREFIX_BYTES[23:16];    // 'H'
			3'd1:    tx_byte = PREFIX_BYTES[15:8];     // 'B'
			3'd2:    tx_byte = PREFIX_BYTES[7:0];      // 'V'
			3'd3:    tx_byte = hex_to_ascii(hv_value_q[15:12]);
			3'd4:    tx_byte = hex_to_ascii(hv_value_q[11:8]);
			3'd5:    tx_byte = hex_to_ascii(hv_value_q[7:4]);
			default: tx_byte = hex_to_ascii(hv_value_q[3:0]);
		endcase
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (hv_accept)
			hv_value_q <= hv_value_i;   // Held for all seven bytes
	end

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state    <= HV_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			byte_idx <= '0;
			hv_tx_o  <= 1'b1;
		end
		else
		begin
			if (state != HV_IDLE)
				baud_cnt <= baud_last ? '0 : baud_cnt + 1'b1;
			case (state)
				HV_IDLE:
					if (hv_accept)
					begin
						byte_idx <= '0;
						hv_tx_o  <= 1'b0;   // Start bit of 'H'
						state    <= HV_START;
					end
				HV_START:
					if (baud_last)
					begin
						bit_cnt <= '0;
						hv_tx_o <= tx_byte[0];
						state   <= HV_DATA;
					end
				HV_DATA:
					if (baud_last)
					begin
						if (bit_cnt == 3'd7)
						begin
							hv_tx_o <= 1'b1;   // Stop bit
							state   <= HV_STOP;
						end
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							hv_tx_o <= tx_byte[bit_cnt + 3'd1];
						end
					end
				HV_STOP:
					if (baud_last)
					begin
						if (byte_idx == (`HV_BYTES - 1))
							state <= HV_IDLE;
						else
						begin
							byte_idx <= byte_idx + 1'b1;
							hv_tx_o  <= 1'b0;   // Next frame, no gap
							state    <= HV_START;
						end
					end
				default: state <= HV_IDLE;
			endcase
		end
	end

	// Line must rest at mark level between commands
	a_tx_idle: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		(state == HV_IDLE) |-> hv_tx_o);

endmodule

// ==== logic/dif_top.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module dif_top
(
	input  logic              rst_n_i,
	input  logic              Clk_Out_2_All,
	input  logic              cmd_valid_i,
	input  logic [`CMD_W-1:0] cmd_word_i,
	output logic              sr_ck_o,       // ASIC slow control
	output logic              sr_in_o,
	output logic              sc_busy_o,
	output logic              dac_sclk_o,    // Calibration DAC
	output logic              dac_din_o,
	output logic              dac_cs_n_o,
	output logic              dac_busy_o,
	output logic              hv_tx_o,       // HV module UART
	output logic              hv_busy_o
);
	import dif_pkg::*;

	sc_frame_t                sc_frame;
	logic                     sc_start;
	logic [`DAC_CODE_W-1:0]   dac_code;
	logic                     dac_start;
	logic [`HV_VALUE_W-1:0]   hv_value;
	logic                     hv_start;

	//////////////////////////////////////////////////////////////
	// Host command decode
	//////////////////////////////////////////////////////////////
	cmd_decoder u_cmd_decoder
	(
		.rst_n_i       (rst_n_i),
		.Clk_Out_2_All (Clk_Out_2_All),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_word_i    (cmd_word_i),
		.sc_frame_o    (sc_frame),
		.sc_start_o    (sc_start),
		.dac_code_o    (dac_code),
		.dac_start_o   (dac_start),
		.hv_value_o    (hv_value),
		.hv_start_o    (hv_start)
	);

	//////////////////////////////////////////////////////////////
	// Serial engines, each on its own pins
	//////////////////////////////////////////////////////////////
	sc_loader u_sc_loader
	(
		.rst_n_i       (rst_n_i),
		.Clk_Out_2_All (Clk_Out_2_All),
		.sc_frame_i    (sc_frame),
		.sc_start_i    (sc_start),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.sc_busy_o     (sc_busy_o)
	);

	dac_spi_writer u_dac_spi_writer
	(
		.rst_n_i       (rst_n_i),
		.Clk_Out_2_All (Clk_Out_2_All),
		.dac_code_i    (dac_code),
		.dac_start_i   (dac_start),
		.dac_sclk_o    (dac_sclk_o),
		.dac_din_o     (dac_din_o),
		.dac_cs_n_o    (dac_cs_n_o),
		.dac_busy_o    (dac_busy_o)
	);

	hv_cmd_sender u_hv_cmd_sender
	(
		.rst_n_i       (rst_n_i),
		.Clk_Out_2_All (Clk_Out_2_All),
		.hv_value_i    (hv_value),
		.hv_start_i    (hv_start),
		.hv_tx_o       (hv_tx_o),
		.hv_busy_o     (hv_busy_o)
	);

endmodule

// ==== dv/dif_checker.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module dif_checker
(
	input  logic              rst_n_i,
	input  logic              Clk_Out_2_All,
	input  logic              cmd_valid_i,
	input  logic [`CMD_W-1:0] cmd_word_i,
	input  logic              sr_ck_i,
	input  logic              sr_in_i,
	input  logic              sc_busy_i,
	input  logic              dac_sclk_i,
	input  logic              dac_din_i,
	input  logic              dac_cs_n_i,
	input  logic              dac_busy_i,
	input  logic              hv_tx_i,
	input  logic              hv_busy_i,
	input  logic              end_check_i,   // High once the run is over
	output int                err_cnt_o,
	output int                xfer_cnt_o
);
	import dif_pkg::*;

	localparam int HV_MID = `HV_BAUD_DIV / 2;   // Mid-bit sample point

	string        hex_chars = "0123456789ABCDEF";
	cmd_op_e      op;
	logic [2:0]   busy;       // hv, dac, sc
	logic [2:0]   seen;       // Start command sampled last cycle
	logic [2:0]   took;       // Start accepted and busy due now
	logic [31:0]  frame_m;    // Threshold, cap, val_evt, only_ex_trig, mask
	logic [15:0]  hv_m;
	logic [31:0]  sc_snap;
	logic [11:0]  dac_snap;
	logic [15:0]  hv_snap;
	logic [31:0]  sc_exp_q[$];
	logic [15:0]  dac_exp_q[$];
	logic [15:0]  hv_exp_q[$];
	logic [31:0]  sc_sh;
	logic [15:0]  dac_sh;
	logic [7:0]   rx_byte;
	logic [55:0]  hv_got;
	int           sc_n;
	int           dac_n;
	int           hv_n;
	int           uart_t;     // Cycles into the frame or zero when idle
	logic         ck_q;
	logic         sclk_q;
	logic         tx_q;
	logic         end_done;
	logic         rst_checked;

	assign busy = {hv_busy_i, dac_busy_i, sc_busy_i};

	initial
	begin
		err_cnt_o   = 0;
		xfer_cnt_o  = 0;
		frame_m     = '0;   // All settings zero out of reset
		hv_m        = '0;
		seen        = '0;
		took        = '0;
		sc_n        = 0;
		dac_n       = 0;
		hv_n        = 0;
		uart_t      = 0;
		ck_q        = 1'b0;
		sclk_q      = 1'b0;
		tx_q        = 1'b1;
		end_done    = 1'b0;
		rst_checked = 1'b0;
	end

	// Seven ASCII bytes of one HV command
	function automatic logic [55:0] hv_text(input logic [15:0] v);
		return {"HBV", hex_chars[v[15:12]], hex_chars[v[11:8]],
			hex_chars[v[7:4]], hex_chars[v[3:0]]};
	endfunction

	task automatic report(input string msg);
		$display("ERR @%0t: %s", $time, msg);
		err_cnt_o++;
	endtask

	task automatic compare_xfer(input string what, input logic [55:0] got,
		input logic [55:0] exp);
		xfer_cnt_o++;
		if (got !== exp)
			report($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	//////////////////////////////////////////////////////////////
	// Start acceptance, busy timing and settings model
	//////////////////////////////////////////////////////////////
	always @(posedge Clk_Out_2_All)
	begin
		if (rst_n_i)
		begin
			if (!rst_checked)   // First edge after release
			begin
				rst_checked = 1'b1;
				if (busy != 3'b000 || sr_ck_i || sr_in_i || !dac_cs_n_i ||
					dac_sclk_i || !hv_tx_i)
					report("outputs not at their reset levels");
			end
			for (int e = 0; e < 3; e++)
			begin
				if (took[e] && !busy[e])
					report($sformatf("engine %0d not busy two cycles after start", e));
			end
			took = seen & ~busy;   // Engine sees the pulse one cycle after the word
			if (took[0])
				sc_exp_q.push_back(sc_snap);
			if (took[1])
				dac_exp_q.push_back({`DAC_CTRL_CH_A, dac_snap});
			if (took[2])
				hv_exp_q.push_back(hv_snap);
			seen = '0;
			if (cmd_valid_i)
			begin
				op = cmd_op_e'(cmd_word_i[15:12]);
				case (op)
					OP_SET_THR:     frame_m[31:22] = cmd_word_i[9:0];
					OP_SET_CTRL:
						frame_m[21:16] = {cmd_word_i[3:0], cmd_word_i[4], cmd_word_i[5]};
					OP_SET_MASK_LO: frame_m[7:0]   = cmd_word_i[7:0];
					OP_SET_MASK_HI: frame_m[15:8]  = cmd_word_i[7:0];
					OP_SET_HV_HI:   hv_m[15:8]     = cmd_word_i[7:0];
					OP_SET_HV_LO:   hv_m[7:0]      = cmd_word_i[7:0];
					OP_START_SC:
					begin
						sc_snap = frame_m;
						seen[0] = 1'b1;
					end
					OP_SET_DAC:
					begin
						dac_snap = cmd_word_i[11:0];
						seen[1]  = 1'b1;
					end
					OP_START_HV:
					begin
						hv_snap = hv_m;
						seen[2] = 1'b1;
					end
					default: ;   // Unknown opcode
				endcase
			end

			//////////////////////////////////////////////////////////////
			// Serial decoders
			//////////////////////////////////////////////////////////////
			if (!sc_busy_i)
				sc_n = 0;
			else if (sr_ck_i && !ck_q)   // ASIC rising edge
			begin
				sc_sh = {sc_sh[30:0], sr_in_i};
				sc_n++;
				if (sc_n == `SC_FRAME_W)
				begin
					sc_n = 0;
					if (sc_exp_q.size() == 0)
						report("slow-control load without an accepted start");
					else
						compare_xfer("SC frame", sc_sh, sc_exp_q.pop_front());
				end
			end

			if (!dac_busy_i)
				dac_n = 0;
			else if (sclk_q && !dac_sclk_i && !dac_cs_n_i)   // DAC falling edge
			begin
				dac_sh = {dac_sh[14:0], dac_din_i};
				dac_n++;
				if (dac_n == 16)
				begin
					dac_n = 0;
					if (dac_exp_q.size() == 0)
						report("DAC write without an accepted start");
					else
						compare_xfer("DAC word", dac_sh, dac_exp_q.pop_front());
				end
			end

			if (uart_t == 0)
			begin
				if (!hv_busy_i)
					hv_n = 0;
				if (tx_q && !hv_tx_i)
					uart_t = 1;   // Start edge one cycle back
			end
			else
			begin
				uart_t++;
				if (uart_t % `HV_BAUD_DIV == HV_MID)
				begin
					if (uart_t / `HV_BAUD_DIV == 0 && hv_tx_i)
						report("UART start bit not low at mid-bit");
					else if (uart_t / `HV_BAUD_DIV <= 8)
						rx_byte = {hv_tx_i, rx_byte[7:1]};   // LSB first
					else
					begin
						uart_t = 0;
						if (!hv_tx_i)
							report("UART stop bit not high");
						hv_got = {hv_got[47:0], rx_byte};
						hv_n++;
					end
				end
			end
			if (hv_n == `HV_BYTES)
			begin
				hv_n = 0;
				if (hv_exp_q.size() == 0)
					report("HV command without an accepted start");
				else
					compare_xfer("HV command", hv_got, hv_text(hv_exp_q.pop_front()));
			end

			if (end_check_i && !end_done)
			begin
				end_done = 1'b1;
				if (sc_exp_q.size() + dac_exp_q.size() + hv_exp_q.size() != 0)
				begin
					$display("Some accepted starts never produced a serial transfer");
					err_cnt_o++;
				end
			end
			ck_q   = sr_ck_i;
			sclk_q = dac_sclk_i;
			tx_q   = hv_tx_i;
		end
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`include "dif_defs.svh"

module tb_top;
	import dif_pkg::*;

	localparam int STEPS    = 80;     // Random host commands
	localparam int WAIT_MAX = 3000;   // Cycles, HV command is the longest transfer

	logic              Clk_Out_2_All;
	logic              rst_n_i;
	logic              cmd_valid_i;
	logic [`CMD_W-1:0] cmd_word_i;
	logic              sr_ck_o;
	logic              sr_in_o;
	logic              sc_busy_o;
	logic              dac_sclk_o;
	logic              dac_din_o;
	logic              dac_cs_n_o;
	logic              dac_busy_o;
	logic              hv_tx_o;
	logic              hv_busy_o;
	logic              end_check;      // Tells the checker the run is over
	int                err_cnt;        // Mismatches found by the checker
	int                xfer_cnt;
	int                other_errs;     // Timeouts and missing activity
	int                seed;

	always #2 Clk_Out_2_All = ~Clk_Out_2_All;   // 4 ns period

	dif_top u_dut
	(
		.rst_n_i       (rst_n_i),
		.Clk_Out_2_All (Clk_Out_2_All),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_word_i    (cmd_word_i),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.sc_busy_o     (sc_busy_o),
		.dac_sclk_o    (dac_sclk_o),
		.dac_din_o     (dac_din_o),
		.dac_cs_n_o    (dac_cs_n_o),
		.dac_busy_o    (dac_busy_o),
		.hv_tx_o       (hv_tx_o),
		.hv_busy_o     (hv_busy_o)
	);

	dif_checker u_chk
	(
		.rst_n_i       (rst_n_i),
		.Clk_Out_2_All (Clk_Out_2_All),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_word_i    (cmd_word_i),
		.sr_ck_i       (sr_ck_o),
		.sr_in_i       (sr_in_o),
		.sc_busy_i     (sc_busy_o),
		.dac_sclk_i    (dac_sclk_o),
		.dac_din_i     (dac_din_o),
		.dac_cs_n_i    (dac_cs_n_o),
		.dac_busy_i    (dac_busy_o),
		.hv_tx_i       (hv_tx_o),
		.hv_busy_i     (hv_busy_o),
		.end_check_i   (end_check),
		.err_cnt_o     (err_cnt),
		.xfer_cnt_o    (xfer_cnt)
	);

	//////////////////////////////////////////////////////////////
	// Host word driver and engine idle wait
	//////////////////////////////////////////////////////////////
	task automatic send_word(input logic [3:0] op, input logic [11:0] payload);
		@(negedge Clk_Out_2_All);
		cmd_valid_i = 1'b1;
		cmd_word_i  = {op, payload};
		@(negedge Clk_Out_2_All);
		cmd_valid_i = 1'b0;
		@(negedge Clk_Out_2_All);   // Busy of a taken start is up by now
	endtask

	function automatic logic engine_busy(input int which);
		case (which)
			0:       return sc_busy_o;
			1:       return dac_busy_o;
			default: return hv_busy_o;
		endcase
	endfunction

	task automatic wait_idle(input int which);
		int cycles;
		cycles = 0;
		while (engine_busy(which) && cycles < WAIT_MAX)
		begin
			@(negedge Clk_Out_2_All);
			cycles++;
		end
		if (engine_busy(which))
		begin
			$display("Timeout: engine %0d still busy after %0d cycles", which, WAIT_MAX);
			other_errs++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Reset, random command stream, closing report
	//////////////////////////////////////////////////////////////
	initial
	begin
		int unsigned r;
		int          which;
		int          unk;
		cmd_op_e     op;
		seed          = 32'h5424;
		Clk_Out_2_All = 1'b0;
		rst_n_i       = 1'b0;
		cmd_valid_i   = 1'b0;
		cmd_word_i    = '0;
		end_check     = 1'b0;
		other_errs    = 0;
		repeat (3) @(posedge Clk_Out_2_All);
		@(negedge Clk_Out_2_All);
		rst_n_i = 1'b1;
		for (int i = 0; i < STEPS; i++)
		begin
			r     = $unsigned($random(seed));
			which = (r >> 8) % 3;   // 0 sc, 1 dac, 2 hv
			case (r % 10)
				0, 1, 2, 3, 4:   // Setting with random payload
				begin
					case ((r >> 4) % 6)
						0:       op = OP_SET_THR;
						1:       op = OP_SET_CTRL;
						2:       op = OP_SET_MASK_LO;
						3:       op = OP_SET_MASK_HI;
						4:       op = OP_SET_HV_HI;
						default: op = OP_SET_HV_LO;
					endcase
					send_word(op, r[31:20]);
				end
				5:
				begin
					unk = (r >> 4) % 7;   // 0 or A..F
					send_word((unk == 0) ? 4'h0 : 4'(9 + unk), r[31:20]);
				end
				default:
				begin
					if (r[21:20] != 2'b00)
						wait_idle(which);   // Otherwise start may land on busy
					case (which)
						0:       send_word(OP_START_SC, r[31:20]);
						1:       send_word(OP_SET_DAC, r[31:20]);
						default: send_word(OP_START_HV, r[31:20]);
					endcase
				end
			endcase
		end
		wait_idle(0);
		wait_idle(1);
		wait_idle(2);
		@(negedge Clk_Out_2_All);
		end_check = 1'b1;
		repeat (2) @(negedge Clk_Out_2_All);
		if (xfer_cnt == 0)
		begin
			$display("No serial transfer was observed during the run");
			other_errs++;
		end
		$display("Transfers %0d, compare errors %0d, other errors %0d",
			xfer_cnt, err_cnt, other_errs);
		if (err_cnt == 0 && other_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+common
common/dif_pkg.sv
logic/cmd_decoder.sv
slow_control/sc_loader.sv
logic/dac_spi_writer.sv
hv/hv_cmd_sender.sv
logic/dif_top.sv
dv/dif_checker.sv
dv/tb_top.sv
